// ==== hdl/chiplet_pkg.sv ====
package chiplet_pkg;

    typedef logic [31:0] chiplet_word_t;

    // Body length field, 1 to 15 words per packet
    localparam int PKT_LENGTH_WIDTH = 4;
    localparam int NUM_VC = 2;

    typedef enum logic [2:0] {
        REQ_READ,
        REQ_WRITE,
        REQ_RESP,
        REQ_MSG
    } req_e;

    typedef struct packed {
        logic [3:0] id;
        req_e       req;
        logic       vc;
    } flit_meta_t;

    typedef struct packed {
        flit_meta_t    meta;
        chiplet_word_t payload;
    } flit_t;

    // One entry per received packet, written even when the CRC fails
    typedef struct packed {
        logic [3:0]                  id;
        req_e                        req;
        logic                        vc;
        logic [PKT_LENGTH_WIDTH-1:0] length;
        logic                        crc_ok;
    } rx_meta_t;

    // CRC-32 over the body words only, MSB first, no final inversion
    localparam chiplet_word_t CRC_POLY = 32'h04C11DB7;
    localparam chiplet_word_t CRC_INIT = 32'hFFFFFFFF;

    function automatic chiplet_word_t crc_fold_byte(chiplet_word_t crc, logic [7:0] data);
        chiplet_word_t c;
        logic fb;
        c = crc;
        for (int i = 7; i >= 0; i--) begin
            fb = c[31] ^ data[i];
            c = {c[30:0], 1'b0};
            if (fb) begin
                c = c ^ CRC_POLY;
            end
        end
        return c;
    endfunction

    typedef struct packed {
        logic          cyc;
        logic          stb;
        logic          we;
        logic [1:0]    adr;
        chiplet_word_t dat;
    } wb_m2s_t;

    typedef struct packed {
        logic          ack;
        chiplet_word_t dat;
    } wb_s2m_t;

endpackage

// ==== hdl/chiplet_rx_top.sv ====
`timescale 1ns/1ps

module chiplet_rx_top #(
    parameter int DATA_DEPTH = 16,
    parameter int META_DEPTH = 4
) (
    input  logic                           clk,
    input  logic                           n_rst,
    input  chiplet_pkg::flit_t             flit,
    input  logic                           flit_valid,
    output logic                           flit_ack,
    output logic [chiplet_pkg::NUM_VC-1:0] credit,
    input  chiplet_pkg::wb_m2s_t           wb_in,
    output chiplet_pkg::wb_s2m_t           wb_out
);
    localparam int DATA_CW = $clog2(DATA_DEPTH + 1);
    localparam int META_CW = $clog2(META_DEPTH + 1);

    logic crc_clear, crc_update, crc_done;
    chiplet_pkg::chiplet_word_t crc_word, crc;
    logic data_wen, data_ren, data_full, data_empty;
    chiplet_pkg::chiplet_word_t data_wdata, data_rdata;
    logic [DATA_CW-1:0] data_count;
    logic meta_wen, meta_ren, meta_full, meta_empty;
    chiplet_pkg::rx_meta_t meta_wdata, meta_rdata;
    logic [META_CW-1:0] meta_count;

    rx_fsm u_rx_fsm (
        .clk, .n_rst, .flit, .flit_valid, .flit_ack, .credit,
        .crc_clear, .crc_update, .crc_word, .crc, .crc_done,
        .data_full, .data_wen, .data_wdata,
        .meta_full, .meta_wen, .meta_wdata
    );

    flit_crc u_flit_crc (
        .clk, .n_rst, .clear(crc_clear), .update(crc_update),
        .word(crc_word), .crc, .done(crc_done)
    );

    sync_fifo #(.WIDTH($bits(chiplet_pkg::chiplet_word_t)), .DEPTH(DATA_DEPTH)) u_data_fifo (
        .clk, .n_rst, .wen(data_wen), .wdata(data_wdata), .ren(data_ren),
        .rdata(data_rdata), .full(data_full), .empty(data_empty), .count(data_count)
    );

    sync_fifo #(.WIDTH($bits(chiplet_pkg::rx_meta_t)), .DEPTH(META_DEPTH)) u_meta_fifo (
        .clk, .n_rst, .wen(meta_wen), .wdata(meta_wdata), .ren(meta_ren),
        .rdata(meta_rdata), .full(meta_full), .empty(meta_empty), .count(meta_count)
    );

    rx_wb_slave #(.DATA_CW(DATA_CW), .META_CW(META_CW)) u_rx_wb_slave (
        .clk, .n_rst, .wb_in, .wb_out,
        .data_rdata, .data_empty, .data_full, .data_count, .data_ren,
        .meta_rdata, .meta_empty, .meta_full, .meta_count, .meta_ren
    );

endmodule

// ==== hdl/flit_crc.sv ====
`timescale 1ns/1ps

module flit_crc (
    input  logic                       clk,
    input  logic                       n_rst,
    input  logic                       clear,
    input  logic                       update,
    input  chiplet_pkg::chiplet_word_t word,
    output chiplet_pkg::chiplet_word_t crc,
    output logic                       done
);
    chiplet_pkg::chiplet_word_t crc_q;
    chiplet_pkg::chiplet_word_t word_q;
    logic [1:0] byte_idx;
    logic busy;

    // First byte folds on the update edge, the rest from the shifted copy
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            crc_q    <= chiplet_pkg::CRC_INIT;
            busy     <= 1'b0;
            done     <= 1'b0;
            byte_idx <= 2'd0;
        end else if (clear) begin
            crc_q    <= chiplet_pkg::CRC_INIT;
            busy     <= 1'b0;
            done     <= 1'b0;
            byte_idx <= 2'd0;
        end else if (update) begin
            crc_q    <= chiplet_pkg::crc_fold_byte(crc_q, word[31:24]);
            busy     <= 1'b1;
            done     <= 1'b0;
            byte_idx <= 2'd1;
        end else if (busy) begin
            crc_q    <= chiplet_pkg::crc_fold_byte(crc_q, word_q[31:24]);
            byte_idx <= byte_idx + 2'd1;
            if (byte_idx == 2'd3) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (update) begin
            word_q <= word << 8;
        end else if (busy) begin
            word_q <= word_q << 8;
        end
    end

    assign crc = crc_q;

    // The FSM must wait for done before feeding the next word
    a_no_update_while_busy: assert property (
        @(posedge clk) disable iff (!n_rst) update |-> !busy);

endmodule

// ==== hdl/rx_fsm.sv ====
`timescale 1ns/1ps

module rx_fsm (
    input  logic                               clk,
    input  logic                               n_rst,
    input  chiplet_pkg::flit_t                 flit,
    input  logic                               flit_valid,
    output logic                               flit_ack,
    output logic [chiplet_pkg::NUM_VC-1:0]     credit,
    output logic                               crc_clear,
    output logic                               crc_update,
    output chiplet_pkg::chiplet_word_t         crc_word,
    input  chiplet_pkg::chiplet_word_t         crc,
    input  logic                               crc_done,
    input  logic                               data_full,
    output logic                               data_wen,
    output chiplet_pkg::chiplet_word_t         data_wdata,
    input  logic                               meta_full,
    output logic                               meta_wen,
    output chiplet_pkg::rx_meta_t              meta_wdata
);
    typedef enum logic [2:0] {
        IDLE,
        HEADER,
        CRC_WAIT,
        BODY,
        CRC_CHECK,
        REQ_EN
    } state_e;

    state_e state, next_state;
    logic [chiplet_pkg::PKT_LENGTH_WIDTH-1:0] length_q;
    logic [chiplet_pkg::PKT_LENGTH_WIDTH-1:0] count_q;
    chiplet_pkg::flit_meta_t meta_q;
    logic crc_ok_q;
    logic crc_match;

    assign crc_word   = flit.payload;
    assign data_wdata = flit.payload;
    assign crc_match  = (flit.payload == crc);

    always_comb begin
        next_state = state;
        flit_ack   = 1'b0;
        crc_clear  = 1'b0;
        crc_update = 1'b0;
        data_wen   = 1'b0;
        meta_wen   = 1'b0;
        case (state)
            IDLE: begin
                crc_clear = 1'b1;
                if (flit_valid) begin
                    next_state = HEADER;
                end
            end
            HEADER: begin
                flit_ack   = 1'b1;
                next_state = BODY;
            end
            BODY: begin
                // Remaining words go through the CRC, otherwise this is the CRC flit
                if (flit_valid) begin
                    if (count_q == length_q) begin
                        next_state = CRC_CHECK;
                    end else begin
                        crc_update = 1'b1;
                        next_state = CRC_WAIT;
                    end
                end
            end
            CRC_WAIT: begin
                if (crc_done && !data_full) begin
                    data_wen   = 1'b1;
                    flit_ack   = 1'b1;
                    next_state = BODY;
                end
            end
            CRC_CHECK: begin
                if (!data_full) begin
                    flit_ack   = 1'b1;
                    next_state = REQ_EN;
                end
            end
            REQ_EN: begin
                if (!meta_full) begin
                    meta_wen   = 1'b1;
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    // One credit back on the vc of every consumed flit
    always_comb begin
        credit = '0;
        if (flit_ack) begin
            credit[flit.meta.vc] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state    <= IDLE;
            length_q <= '0;
            count_q  <= '0;
        end else begin
            state <= next_state;
            if (state == HEADER) begin
                length_q <= flit.payload[chiplet_pkg::PKT_LENGTH_WIDTH-1:0];
                count_q  <= '0;
            end else if (data_wen) begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == HEADER) begin
            meta_q <= flit.meta;
        end
        if (state == CRC_CHECK && flit_ack) begin
            crc_ok_q <= crc_match;
        end
    end

    assign meta_wdata = '{
        id:     meta_q.id,
        req:    meta_q.req,
        vc:     meta_q.vc,
        length: length_q,
        crc_ok: crc_ok_q
    };

    a_ack_needs_valid: assert property (
        @(posedge clk) disable iff (!n_rst) flit_ack |-> flit_valid);

    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (!n_rst) data_wen |-> !data_full);

endmodule

// ==== hdl/rx_wb_slave.sv ====
`timescale 1ns/1ps

module rx_wb_slave #(
    parameter int DATA_CW = 5,
    parameter int META_CW = 3
) (
    input  logic                       clk,
    input  logic                       n_rst,
    input  chiplet_pkg::wb_m2s_t       wb_in,
    output chiplet_pkg::wb_s2m_t       wb_out,
    input  chiplet_pkg::chiplet_word_t data_rdata,
    input  logic                       data_empty,
    input  logic                       data_full,
    input  logic [DATA_CW-1:0]         data_count,
    output logic                       data_ren,
    input  chiplet_pkg::rx_meta_t      meta_rdata,
    input  logic                       meta_empty,
    input  logic                       meta_full,
    input  logic [META_CW-1:0]         meta_count,
    output logic                       meta_ren
);
    localparam logic [1:0] ADDR_STATUS = 2'd0;
    localparam logic [1:0] ADDR_META   = 2'd1;
    localparam logic [1:0] ADDR_DATA   = 2'd2;
    localparam int META_PAD = 32 - $bits(chiplet_pkg::rx_meta_t);

    logic req;
    logic ack_q;
    logic pop_data_q, pop_meta_q;
    chiplet_pkg::chiplet_word_t dat_q;
    chiplet_pkg::chiplet_word_t rd_word;

    // New request only in the first cycle of cyc and stb
    assign req = wb_in.cyc && wb_in.stb && !ack_q;

    always_comb begin
        case (wb_in.adr)
            ADDR_STATUS: rd_word = {14'd0, meta_full, data_full,
                                    8'(meta_count), 8'(data_count)};
            ADDR_META:   rd_word = meta_empty ? '0 : {{META_PAD{1'b0}}, meta_rdata};
            ADDR_DATA:   rd_word = data_empty ? '0 : data_rdata;
            default:     rd_word = '0;
        endcase
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            ack_q      <= 1'b0;
            pop_data_q <= 1'b0;
            pop_meta_q <= 1'b0;
        end else begin
            ack_q      <= req;
            // Pop decided with the data capture so an empty read never pops later
            pop_data_q <= req && !wb_in.we && wb_in.adr == ADDR_DATA && !data_empty;
            pop_meta_q <= req && !wb_in.we && wb_in.adr == ADDR_META && !meta_empty;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            dat_q <= wb_in.we ? '0 : rd_word;
        end
    end

    assign data_ren = pop_data_q;
    assign meta_ren = pop_meta_q;
    assign wb_out   = '{ack: ack_q, dat: dat_q};

    a_ack_in_cycle: assert property (
        @(posedge clk) disable iff (!n_rst) ack_q |-> (wb_in.cyc && wb_in.stb));

endmodule

// ==== hdl/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  logic                         clk,
    input  logic                         n_rst,
    input  logic                         wen,
    input  logic [WIDTH-1:0]             wdata,
    input  logic                         ren,
    output logic [WIDTH-1:0]             rdata,
    output logic                         full,
    output logic                         empty,
    output logic [$clog2(DEPTH+1)-1:0]   count
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0] wptr, rptr;
    logic [CW-1:0] count_q;
    logic do_write, do_read;

    assign do_write = wen && !full;
    assign do_read  = ren && !empty;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            wptr    <= '0;
            rptr    <= '0;
            count_q <= '0;
        end else begin
            if (do_write) begin
                wptr <= (wptr == AW'(DEPTH - 1)) ? '0 : wptr + 1'b1;
            end
            if (do_read) begin
                rptr <= (rptr == AW'(DEPTH - 1)) ? '0 : rptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wptr] <= wdata;
        end
    end

    // Head entry is visible without a read
    assign rdata = mem[rptr];
    assign full  = (count_q == CW'(DEPTH));
    assign empty = (count_q == '0);
    assign count = count_q;

    a_count_bound: assert property (
        @(posedge clk) disable iff (!n_rst) count_q <= CW'(DEPTH));

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the chiplet receive testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_chiplet_rx -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

echo "$out" | grep -q '^>>> PASS$'

// ==== tests/rx_checker.sv ====
`timescale 1ns/1ps

module rx_checker (
    input  logic                           clk,
    input  logic                           n_rst,
    input  logic                           flit_ack,
    input  logic [chiplet_pkg::NUM_VC-1:0] credit,
    input  chiplet_pkg::wb_m2s_t           wb_in,
    input  chiplet_pkg::wb_s2m_t           wb_out,
    input  logic                           push_vc,
    input  logic                           exp_vc,
    input  logic                           push_rd,
    input  logic [31:0]                    exp_rd_dat,
    input  logic [31:0]                    exp_rd_mask,
    input  logic                           hold_chk,
    input  logic                           final_chk,
    output int                             errors
);
    logic        exp_vc_q[$];
    logic [63:0] exp_rd_q[$];
    int vc_expected[chiplet_pkg::NUM_VC];
    int vc_seen[chiplet_pkg::NUM_VC];
    int stb_cycles;
    logic final_done;

    // Expected values are taken on the rising edge, the driver changes them 1 ns later
    always @(posedge clk) begin
        if (!n_rst) begin
            exp_vc_q.delete();
            exp_rd_q.delete();
            for (int v = 0; v < chiplet_pkg::NUM_VC; v++) begin
                vc_expected[v] = 0;
            end
        end else begin
            if (push_vc) begin
                exp_vc_q.push_back(exp_vc);
                vc_expected[exp_vc] = vc_expected[exp_vc] + 1;
            end
            if (push_rd) begin
                exp_rd_q.push_back({exp_rd_mask, exp_rd_dat});
            end
        end
    end

    always @(negedge clk) begin
        logic [chiplet_pkg::NUM_VC-1:0] want;
        logic [63:0] e;
        logic v;
        if (!n_rst) begin
            errors = 0;
            stb_cycles = 0;
            final_done = 1'b0;
            for (int i = 0; i < chiplet_pkg::NUM_VC; i++) begin
                vc_seen[i] = 0;
            end
        end else begin
            want = '0;
            if (flit_ack) begin
                if (exp_vc_q.size() == 0) begin
                    $display("Error at %0t: flit_ack with no flit being sent", $time);
                    errors++;
                end else begin
                    v = exp_vc_q.pop_front();
                    want[v] = 1'b1;
                end
            end
            if (credit !== want) begin
                $display("Error at %0t: credit expected %b got %b", $time, want, credit);
                errors++;
            end
            for (int i = 0; i < chiplet_pkg::NUM_VC; i++) begin
                if (credit[i] === 1'b1) begin
                    vc_seen[i] = vc_seen[i] + 1;
                end
            end

            // Data FIFO is full and no host read is pending
            if (hold_chk && flit_ack) begin
                $display("Error at %0t: flit_ack raised while the data FIFO was full", $time);
                errors++;
            end

            if (wb_out.ack && !(wb_in.cyc && wb_in.stb)) begin
                $display("Error at %0t: ack raised outside a bus cycle", $time);
                errors++;
            end
            if (wb_in.cyc && wb_in.stb) begin
                if (wb_out.ack) begin
                    if (stb_cycles != 1) begin
                        $display("Error at %0t: ack came after %0d cycles of stb, not 1",
                                 $time, stb_cycles);
                        errors++;
                    end
                    if (exp_rd_q.size() == 0) begin
                        $display("Error at %0t: read acknowledged with no read issued", $time);
                        errors++;
                    end else begin
                        e = exp_rd_q.pop_front();
                        if (((wb_out.dat ^ e[31:0]) & e[63:32]) != 32'd0) begin
                            $display("Error at %0t: wb_out.dat expected %h got %h (adr %0d)",
                                     $time, e[31:0], wb_out.dat, wb_in.adr);
                            errors++;
                        end
                    end
                    stb_cycles = 0;
                end else begin
                    stb_cycles++;
                end
            end else begin
                stb_cycles = 0;
            end

            // Totals per vc, header plus body plus CRC flits
            if (final_chk && !final_done) begin
                final_done = 1'b1;
                for (int i = 0; i < chiplet_pkg::NUM_VC; i++) begin
                    if (vc_seen[i] != vc_expected[i]) begin
                        $display("Error at %0t: credit count on vc %0d expected %0d got %0d",
                                 $time, i, vc_expected[i], vc_seen[i]);
                        errors++;
                    end
                end
                if (exp_vc_q.size() != 0 || exp_rd_q.size() != 0) begin
                    $display("Some sent flits or issued reads were never acknowledged");
                    errors++;
                end
            end
        end
    end

endmodule

// ==== tests/rx_trace.txt ====
# Packet records, all values hex: id req vc length corrupt hold, then the body words
# corrupt inverts the CRC flit (crc_ok expected clear), hold delays host reads until full
1 0 0 3 0 0
  deadbeef 01234567 89abcdef
2 1 1 1 0 0
  cafef00d
3 2 0 4 1 0
  11111111 22222222 33333333 44444444
4 3 1 2 0 0
  a5a5a5a5 5a5a5a5a
5 1 0 a 0 1
  00000001 00000002 00000003 00000004 00000005
  00000006 00000007 00000008 00000009 0000000a
6 0 1 c 0 1
  10000001 20000002 30000003 40000004 50000005 60000006
  70000007 80000008 90000009 a000000a b000000b c000000c
7 2 1 f 0 0
  f0e1d2c3 b4a59687 78695a4b 3c2d1e0f 00ff00ff
  ff00ff00 13579bdf 2468ace0 0badcafe feedface
  12345678 9abcdef0 0f0f0f0f f0f0f0f0 55aa55aa
8 1 1 5 1 0
  c0ffee00 beadbead 7777aaaa 00000000 ffffffff
9 3 0 1 0 0
  80000000

// ==== tests/tb_chiplet_rx.sv ====
`timescale 1ns/1ps

module tb_chiplet_rx;
    localparam int DATA_DEPTH  = 16;
    localparam int META_DEPTH  = 4;
    localparam int ACK_TIMEOUT = 500;
    localparam int POLL_LIMIT  = 100;

    logic clk;
    logic n_rst;
    chiplet_pkg::flit_t flit;
    logic flit_valid;
    logic flit_ack;
    logic [chiplet_pkg::NUM_VC-1:0] credit;
    chiplet_pkg::wb_m2s_t wb_in;
    chiplet_pkg::wb_s2m_t wb_out;

    logic push_vc, exp_vc, push_rd, hold_chk, final_chk;
    logic [31:0] exp_rd_dat, exp_rd_mask;
    int errors;
    int seed;

    logic [31:0] body_q[$];
    logic [31:0] pend_words[$];
    logic [31:0] pend_meta[$];

    chiplet_rx_top #(.DATA_DEPTH(DATA_DEPTH), .META_DEPTH(META_DEPTH)) uut (
        .clk, .n_rst, .flit, .flit_valid, .flit_ack, .credit, .wb_in, .wb_out
    );

    rx_checker chk (
        .clk, .n_rst, .flit_ack, .credit, .wb_in, .wb_out,
        .push_vc, .exp_vc, .push_rd, .exp_rd_dat, .exp_rd_mask,
        .hold_chk, .final_chk, .errors
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $finish;
    endtask

    // Running CRC-32, MSB first over the whole word
    function automatic logic [31:0] crc_next(input logic [31:0] c_in, input logic [31:0] w);
        logic [31:0] c;
        logic fb;
        c = c_in;
        for (int i = 31; i >= 0; i--) begin
            fb = c[31] ^ w[i];
            c = {c[30:0], 1'b0} ^ (fb ? chiplet_pkg::CRC_POLY : 32'h0);
        end
        return c;
    endfunction

    // Called 1 ns after a rising edge, returns at the same phase
    task automatic send_flit(input chiplet_pkg::flit_meta_t m, input logic [31:0] payload);
        int n;
        int gap;
        flit = '{meta: m, payload: payload};
        flit_valid = 1'b1;
        push_vc = 1'b1;
        exp_vc = m.vc;
        @(posedge clk);
        #1;
        push_vc = 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!flit_ack && n < ACK_TIMEOUT);
        if (!flit_ack) begin
            abort_run("Timeout waiting for flit_ack");
        end
        @(posedge clk);
        #1;
        gap = $random(seed) & 3;
        if (gap != 0) begin
            flit_valid = 1'b0;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic send_packet(input chiplet_pkg::flit_meta_t m, input logic [3:0] len,
                               input logic corrupt);
        logic [31:0] c;
        c = chiplet_pkg::CRC_INIT;
        send_flit(m, {28'd0, len});
        foreach (body_q[i]) begin
            send_flit(m, body_q[i]);
            c = crc_next(c, body_q[i]);
        end
        send_flit(m, corrupt ? ~c : c);
        flit_valid = 1'b0;
        // Room for the metadata write before any STATUS read
        @(posedge clk);
        #1;
    endtask

    task automatic wb_read(input logic [1:0] addr, input logic [31:0] exp_val,
                           input logic [31:0] mask, output logic [31:0] dat);
        int n;
        wb_in.cyc = 1'b1;
        wb_in.stb = 1'b1;
        wb_in.we = 1'b0;
        wb_in.adr = addr;
        push_rd = 1'b1;
        exp_rd_dat = exp_val;
        exp_rd_mask = mask;
        @(posedge clk);
        #1;
        push_rd = 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!wb_out.ack && n < ACK_TIMEOUT);
        if (!wb_out.ack) begin
            abort_run("Timeout waiting for the Wishbone ack");
        end
        dat = wb_out.dat;
        @(posedge clk);
        #1;
        wb_in.cyc = 1'b0;
        wb_in.stb = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic drain_all();
        logic [31:0] st;
        logic [31:0] d;
        st = {14'd0, pend_meta.size() == META_DEPTH, pend_words.size() == DATA_DEPTH,
              8'(pend_meta.size()), 8'(pend_words.size())};
        wb_read(2'd0, st, 32'hFFFFFFFF, d);
        while (pend_words.size() > 0) begin
            wb_read(2'd2, pend_words.pop_front(), 32'hFFFFFFFF, d);
        end
        while (pend_meta.size() > 0) begin
            wb_read(2'd1, pend_meta.pop_front(), 32'hFFFFFFFF, d);
        end
    endtask

    // Host holds off until the data FIFO is full, then checks the stall and drains it
    task automatic wait_full_and_drain();
        logic [31:0] st;
        int polls;
        polls = 0;
        do begin
            wb_read(2'd0, 32'd0, 32'd0, st);
            polls++;
        end while (!st[16] && polls < POLL_LIMIT);
        if (!st[16]) begin
            abort_run("Timeout waiting for the data FIFO to fill");
        end
        hold_chk = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        hold_chk = 1'b0;
        repeat (DATA_DEPTH) begin
            wb_read(2'd2, pend_words.pop_front(), 32'hFFFFFFFF, st);
        end
    endtask

    initial begin
        int fd;
        int code;
        int pkts;
        string tok;
        logic [8*128-1:0] line;
        logic [3:0] id;
        logic [3:0] len;
        logic [2:0] req;
        logic vc, corrupt, hold;
        logic [31:0] w;
        logic [31:0] d;
        chiplet_pkg::flit_meta_t m;

        seed = 44;
        n_rst = 1'b0;
        flit = '0;
        flit_valid = 1'b0;
        wb_in = '0;
        push_vc = 1'b0;
        exp_vc = 1'b0;
        push_rd = 1'b0;
        exp_rd_dat = 32'd0;
        exp_rd_mask = 32'd0;
        hold_chk = 1'b0;
        final_chk = 1'b0;
        pkts = 0;

        repeat (5) @(posedge clk);
        #1;
        n_rst = 1'b1;
        @(posedge clk);
        #1;
        wb_read(2'd0, 32'd0, 32'hFFFFFFFF, d);

        fd = $fopen("tests/rx_trace.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open the trace file tests/rx_trace.txt");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                break;
            end
            if (tok.len() > 0 && tok[0] == 8'h23) begin
                code = $fgets(line, fd);
                continue;
            end
            code = $sscanf(tok, "%h", id);
            code = $fscanf(fd, "%h %h %h %h %h", req, vc, len, corrupt, hold);
            if (code != 5) begin
                abort_run("Malformed packet line in the trace");
            end
            body_q.delete();
            for (int i = 0; i < int'(len); i++) begin
                code = $fscanf(fd, "%h", w);
                body_q.push_back(w);
                pend_words.push_back(w);
            end
            m = '{id: id, req: chiplet_pkg::req_e'(req), vc: vc};
            pend_meta.push_back({19'd0, id, req, vc, len, !corrupt});

            if (hold && pend_words.size() > DATA_DEPTH) begin
                fork
                    send_packet(m, len, corrupt);
                    wait_full_and_drain();
                join
                drain_all();
            end else begin
                send_packet(m, len, corrupt);
                if (!hold) begin
                    drain_all();
                end
            end
            pkts++;
        end
        $fclose(fd);

        // Empty FIFOs and the unused address read zero
        wb_read(2'd2, 32'd0, 32'hFFFFFFFF, d);
        wb_read(2'd1, 32'd0, 32'hFFFFFFFF, d);
        wb_read(2'd3, 32'd0, 32'hFFFFFFFF, d);
        wb_read(2'd0, 32'd0, 32'hFFFFFFFF, d);

        final_chk = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        $display("Packets %0d, errors %0d", pkts, errors);
        if (errors == 0 && pkts > 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
hdl/chiplet_pkg.sv
hdl/flit_crc.sv
hdl/sync_fifo.sv
hdl/rx_fsm.sv
hdl/rx_wb_slave.sv
hdl/chiplet_rx_top.sv
tests/rx_checker.sv
tests/tb_chiplet_rx.sv
